//--- sources.f
src/stat_types_pkg.sv
src/stat_ctrl_pkg.sv
src/stream_distrib.sv
src/lane_sum.sv
src/lane_extrema.sv
src/lane_energy.sv
src/stat_ctrl.sv
src/block_stats_top.sv
test/block_stats_sva.sv
test/block_stats_tb.sv

//--- src/block_stats_top.sv
/*
  block statistics engine
  control, distributor and the sum, extrema and energy lanes
*/

`timescale 1ns/1ns

module block_stats_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cmd_valid,
  input  stat_ctrl_pkg::ctrl_cmd_t     cmd,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  stat_types_pkg::sample_t      in_data,
  output logic                         done,
  output stat_types_pkg::stat_result_t result
);

  import stat_types_pkg::*;

  logic                    run;
  logic                    clear;
  logic                    in_fire;
  logic                    pending;
  logic                    busy;
  logic [NUM_LANES-1:0]    lane_valid;
  logic [NUM_LANES-1:0]    lane_ready;
  sample_t                 lane_data;
  logic signed [ACC_W-1:0] sum;
  sample_t                 min;
  sample_t                 max;
  logic [ACC_W-1:0]        energy;

  // input handshake seen by the counter
  assign in_fire = in_valid & in_ready;

  stat_ctrl u_stat_ctrl (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .in_fire(in_fire),
    .pending(pending), .busy(busy), .run(run), .clear(clear), .done(done)
  );

  stream_distrib u_stream_distrib (
    .clk(clk), .rst(rst), .in_valid(in_valid), .run(run), .in_ready(in_ready),
    .in_data(in_data), .lane_valid(lane_valid), .lane_ready(lane_ready),
    .lane_data(lane_data), .pending(pending)
  );

  // lane 0 sum, lane 1 extrema, lane 2 energy
  lane_sum u_lane_sum (
    .clk(clk), .rst(rst), .clear(clear), .valid(lane_valid[0]),
    .ready(lane_ready[0]), .data(lane_data), .sum(sum)
  );

  lane_extrema u_lane_extrema (
    .clk(clk), .rst(rst), .clear(clear), .valid(lane_valid[1]),
    .ready(lane_ready[1]), .data(lane_data), .min(min), .max(max)
  );

  lane_energy u_lane_energy (
    .clk(clk), .rst(rst), .clear(clear), .valid(lane_valid[2]),
    .ready(lane_ready[2]), .busy(busy), .data(lane_data), .energy(energy)
  );

  assign result = '{sum: sum, min: min, max: max, energy: energy};

endmodule

//--- src/lane_energy.sv
/*
  energy lane
  squares each sample with a shift-add multiplier and
  accumulates the result, stalling while it multiplies
*/

`timescale 1ns/1ns

module lane_energy (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             clear,
  input  logic                             valid,
  output logic                             ready,
  output logic                             busy,
  input  stat_types_pkg::sample_t          data,
  output logic [stat_types_pkg::ACC_W-1:0] energy
);

  import stat_types_pkg::*;

  // magnitude of the incoming sample, 0x8000 for the most negative
  logic [SAMPLE_W-1:0]         mag;
  // multiplier bits, shifted right each step
  logic [SAMPLE_W-1:0]         mult_a;
  // shifted multiplicand and partial product
  logic [2*SAMPLE_W-1:0]       mcand;
  logic [2*SAMPLE_W-1:0]       prod;
  logic [$clog2(SAMPLE_W)-1:0] step;
  // product ready, add on the next edge
  logic                        add_pend;
  logic                        fire;

  assign mag   = data[SAMPLE_W-1] ? (~data + 1'b1) : data;
  assign ready = ~busy;
  assign fire  = valid & ready;

  //////////////////////////////
  // control and accumulator
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      add_pend <= 1'b0;
      step     <= '0;
      energy   <= '0;
    end else begin
      add_pend <= 1'b0;
      // clear only arrives while idle
      if (clear) begin
        energy <= '0;
      end else if (add_pend) begin
        energy <= energy + ACC_W'(prod);
      end
      if (fire) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        // last multiply step
        if (step == SAMPLE_W - 1) begin
          busy     <= 1'b0;
          add_pend <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // shift-add datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (fire) begin
      mult_a <= mag;
      mcand  <= {{SAMPLE_W{1'b0}}, mag};
      prod   <= '0;
    end else if (busy) begin
      if (mult_a[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mult_a <= mult_a >> 1;
    end
  end

endmodule

//--- src/lane_extrema.sv
/*
  extrema lane
  running signed minimum and maximum since the last clear
*/

`timescale 1ns/1ns

module lane_extrema (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    valid,
  output logic                    ready,
  input  stat_types_pkg::sample_t data,
  output stat_types_pkg::sample_t min,
  output stat_types_pkg::sample_t max
);

  import stat_types_pkg::*;

  // starting values, any sample replaces them
  sample_t pos_limit;
  sample_t neg_limit;
  logic    fire;

  assign pos_limit = {1'b0, {(SAMPLE_W-1){1'b1}}};
  assign neg_limit = {1'b1, {(SAMPLE_W-1){1'b0}}};

  // compare is one cycle, always ready
  assign ready = 1'b1;
  assign fire  = valid & ready;

  //////////////////////////////
  // min / max registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      min <= pos_limit;
      max <= neg_limit;
    end else if (fire) begin
      // signed compare, both may change on the first sample
      if (data < min) begin
        min <= data;
      end
      if (data > max) begin
        max <= data;
      end
    end
  end

endmodule

//--- src/lane_sum.sv
/*
  sum lane
  signed running sum of all samples since the last clear
*/

`timescale 1ns/1ns

module lane_sum (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clear,
  input  logic                                  valid,
  output logic                                  ready,
  input  stat_types_pkg::sample_t               data,
  output logic signed [stat_types_pkg::ACC_W-1:0] sum
);

  import stat_types_pkg::*;

  // sign-extended sample
  logic signed [ACC_W-1:0] data_ext;
  logic                    fire;

  // single-cycle add, never stalls
  assign ready = 1'b1;
  assign fire  = valid & ready;

  assign data_ext = {{(ACC_W-SAMPLE_W){data[SAMPLE_W-1]}}, data};

  //////////////////////////////
  // accumulator
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (fire) begin
      // update on the handshake edge
      sum <= sum + data_ext;
    end
  end

endmodule

//--- src/stat_ctrl.sv
/*
  statistics control
  decodes commands, counts accepted samples, waits for the
  lanes to drain and pulses done at the end of a block
*/

`timescale 1ns/1ns

module stat_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  input  stat_ctrl_pkg::ctrl_cmd_t cmd,
  input  logic                     in_fire,
  input  logic                     pending,
  input  logic                     busy,
  output logic                     run,
  output logic                     clear,
  output logic                     done
);

  import stat_types_pkg::*;
  import stat_ctrl_pkg::*;

  ctrl_state_t      state;
  // samples still to accept in this block
  logic [LEN_W-1:0] remaining;

  // stream only flows in ST_RUN
  assign run = (state == ST_RUN);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      remaining <= '0;
      clear     <= 1'b0;
      done      <= 1'b0;
    end else begin
      // single-cycle pulses
      clear <= 1'b0;
      done  <= 1'b0;
      case (state)
        ST_IDLE: begin
          // commands only honored here
          if (cmd_valid) begin
            case (cmd.op)
              OP_CLEAR: begin
                clear <= 1'b1;
              end
              OP_BLOCK: begin
                if (cmd.len == '0) begin
                  // empty block, finish at once
                  done <= 1'b1;
                end else begin
                  remaining <= cmd.len;
                  state     <= ST_RUN;
                end
              end
              default: begin
              end
            endcase
          end
        end
        ST_RUN: begin
          if (in_fire) begin
            remaining <= remaining - 1'b1;
            // last sample accepted
            if (remaining == 1) begin
              state <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          // lanes idle and nothing in flight
          if (!pending && !busy) begin
            done  <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/stat_ctrl_pkg.sv
/*
  block statistics control types
  opcodes, FSM states and the command record
*/

package stat_ctrl_pkg;

  // command opcodes
  typedef enum logic [0:0] {
    OP_CLEAR,
    OP_BLOCK
  } opcode_t;

  // control FSM states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } ctrl_state_t;

  // single-cycle command strobe payload
  typedef struct packed {
    opcode_t                          op;
    logic [stat_types_pkg::LEN_W-1:0] len;
  } ctrl_cmd_t;

endpackage

//--- src/stat_types_pkg.sv
/*
  block statistics data types
  widths, lane count, sample format and the result record
*/

package stat_types_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // lanes fed by the distributor: sum, extrema, energy
  localparam int NUM_LANES = 3;
  localparam int SAMPLE_W  = 16;
  // accumulator width, headroom for long blocks
  localparam int ACC_W     = 40;
  // block length field
  localparam int LEN_W     = 10;

  // one signed input sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // statistics over all blocks since the last clear
  typedef struct packed {
    logic signed [ACC_W-1:0] sum;
    sample_t                 min;
    sample_t                 max;
    logic [ACC_W-1:0]        energy;
  } stat_result_t;

endpackage

//--- src/stream_distrib.sv
/*
  stream distributor
  copies each accepted sample to every statistic lane and takes
  the next sample only once all lanes have taken the current one
*/

`timescale 1ns/1ns

module stream_distrib (
  input  logic                                 clk,
  input  logic                                 rst,
  // upstream sample port
  input  logic                                 in_valid,
  input  logic                                 run,
  output logic                                 in_ready,
  input  stat_types_pkg::sample_t              in_data,
  // lane side
  output logic [stat_types_pkg::NUM_LANES-1:0] lane_valid,
  input  logic [stat_types_pkg::NUM_LANES-1:0] lane_ready,
  output stat_types_pkg::sample_t              lane_data,
  output logic                                 pending
);

  import stat_types_pkg::*;

  // lanes that already took the current sample
  logic [NUM_LANES-1:0] done_mask;
  // per-lane handshake this cycle
  logic [NUM_LANES-1:0] lane_fire;
  logic [NUM_LANES-1:0] done_next;
  logic                 in_fire;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  assign lane_fire = lane_valid & lane_ready;
  // lanes completing this cycle count as done
  assign done_next = done_mask | lane_fire;

  // accept only while running and with every lane free
  assign in_ready = run & (&done_next);
  assign in_fire  = in_valid & in_ready;

  //////////////////////////////
  // done mask
  //////////////////////////////

  // all ones when idle, so nothing outstanding after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      done_mask <= '1;
    end else if (in_fire) begin
      // new sample, every lane owes a handshake
      done_mask <= '0;
    end else begin
      done_mask <= done_next;
    end
  end

  // a lane stays valid until it has taken the sample
  assign lane_valid = ~done_mask;
  assign pending    = |lane_valid;

  // sample register, loaded once per accepted input
  always_ff @(posedge clk) begin
    if (in_fire) begin
      lane_data <= in_data;
    end
  end

endmodule

//--- test/block_stats_sva.sv
/*
  block statistics assertions
  handshake stability, done pulse width and run gating
*/

`timescale 1ns/1ns

module block_stats_sva (
  input logic                                 clk,
  input logic                                 rst,
  input logic [stat_types_pkg::NUM_LANES-1:0] lane_valid,
  input logic [stat_types_pkg::NUM_LANES-1:0] lane_ready,
  input stat_types_pkg::sample_t              lane_data,
  input logic                                 in_ready,
  input logic                                 run,
  input logic                                 done
);

  // shared sample held while a lane still owes a handshake
  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    |(lane_valid & ~lane_ready) |=> $stable(lane_data))
    else $error("lane_data changed while a lane was still valid");

  // single-cycle done
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done held high for more than one cycle");

  // no input accepted outside the run state
  a_ready_gated: assert property (@(posedge clk) disable iff (rst) !run |-> !in_ready)
    else $error("input accepted while not in the run state");

endmodule

// distributor side, done and gating signals tied off
bind stream_distrib block_stats_sva u_distrib_sva (
  .clk(clk), .rst(rst), .lane_valid(lane_valid), .lane_ready(lane_ready),
  .lane_data(lane_data), .in_ready(1'b0), .run(1'b0), .done(1'b0)
);

// control side, the input handshake stands in for in_ready
bind stat_ctrl block_stats_sva u_ctrl_sva (
  .clk(clk), .rst(rst), .lane_valid('0), .lane_ready('0), .lane_data('0),
  .in_ready(in_fire), .run(run), .done(done)
);

//--- test/block_stats_tb.sv
/*
  block statistics testbench
  directed tests against a reference model fed by observed handshakes
*/

`timescale 1ns/1ns

module block_stats_tb;

  import stat_types_pkg::*;
  import stat_ctrl_pkg::*;

  localparam int DONE_LIMIT  = 2000;
  localparam int READY_LIMIT = 100;

  logic clk = 1'b0;
  logic rst, cmd_valid, in_valid, in_ready, done;
  ctrl_cmd_t    cmd;
  sample_t      in_data;
  stat_result_t result;

  // reference model state
  logic signed [ACC_W-1:0] ref_sum;
  sample_t                 ref_min, ref_max;
  logic [ACC_W-1:0]        ref_energy;
  logic [15:0]             lfsr_state = 16'd94;
  int errors = 0, checks = 0, fire_count = 0, done_count = 0;
  sample_t fixed_set [8] = '{16'sd100, -16'sd250, 16'sh7fff, 16'sh8000,
                             16'sd0, 16'sd1, -16'sd1, 16'sd12345};

  block_stats_top u_block_stats_top (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .in_valid(in_valid),
    .in_ready(in_ready), .in_data(in_data), .done(done), .result(result)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // LFSR and reference model
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    end
    return v;
  endfunction

  task automatic model_clear();
    ref_sum    = '0;
    ref_min    = 16'sh7fff;
    ref_max    = 16'sh8000;
    ref_energy = '0;
  endtask

  // inputs and in_ready settled by the falling edge, transfer on the next rise
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) begin
      fire_count++;
      ref_sum    = ref_sum + in_data;
      ref_energy = ref_energy + ACC_W'(longint'(in_data) * longint'(in_data));
      if (in_data < ref_min) ref_min = in_data;
      if (in_data > ref_max) ref_max = in_data;
    end
    if (!rst && done) done_count++;
  end

  //////////////////////////////
  // drivers and checks
  //////////////////////////////

  task automatic check_field(input string test, input string field,
                             input logic [ACC_W-1:0] exp, input logic [ACC_W-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  task automatic check_results(input string test);
    check_field(test, "sum", ref_sum, result.sum);
    check_field(test, "min", ref_min, result.min);
    check_field(test, "max", ref_max, result.max);
    check_field(test, "energy", ref_energy, result.energy);
  endtask

  task automatic send_cmd(input opcode_t op, input int len);
    cmd_valid = 1'b1;
    cmd       = '{op: op, len: LEN_W'(len)};
    @(posedge clk);
    #1 cmd_valid = 1'b0;
  endtask

  // hold the sample until the DUT takes it, in_valid left high
  task automatic push_sample(input sample_t value);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_data  = value;
    @(negedge clk);
    while (!in_ready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      errors++;
      $display("timed out waiting for in_ready, sample %h", value);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_done(input string test, input int base);
    int waited;
    waited = 0;
    while (done_count == base && waited < DONE_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (done_count == base) begin
      errors++;
      $display("%s timed out waiting for done", test);
    end
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_and_empty();
    int base;
    check_field("reset", "in_ready", 1'b0, in_ready);
    check_field("reset", "done", 1'b0, done);
    model_clear();
    send_cmd(OP_CLEAR, 0);
    base = done_count;
    send_cmd(OP_BLOCK, 0);
    wait_done("reset", base);
    check_results("reset");
  endtask

  task automatic run_fixed(input string test, input int first, input int count);
    int base;
    base = done_count;
    send_cmd(OP_BLOCK, count);
    for (int i = first; i < first + count; i++) push_sample(fixed_set[i]);
    in_valid = 1'b0;
    wait_done(test, base);
  endtask

  task automatic test_fixed_block();
    model_clear();
    send_cmd(OP_CLEAR, 0);
    run_fixed("fixed8", 0, 8);
    check_results("fixed8");
  endtask

  task automatic test_accumulate();
    model_clear();
    send_cmd(OP_CLEAR, 0);
    run_fixed("accum", 0, 4);
    run_fixed("accum", 4, 4);
    // both blocks together
    check_results("accum");
    model_clear();
    send_cmd(OP_CLEAR, 0);
    run_fixed("accum_clr", 2, 5);
    check_results("accum_clr");
  endtask

  task automatic test_random_gaps();
    int base, fires;
    model_clear();
    send_cmd(OP_CLEAR, 0);
    base  = done_count;
    fires = fire_count;
    send_cmd(OP_BLOCK, 24);
    for (int i = 0; i < 24; i++) begin
      // gap of 0..3 idle cycles before the sample
      in_valid = 1'b0;
      repeat (take_bits(2)) @(posedge clk);
      #1 push_sample(sample_t'(take_bits(16)));
    end
    // keep offering a sample past len, none may be taken
    wait_done("random", base);
    in_valid = 1'b0;
    check_field("random", "handshakes", 24, fire_count - fires);
    check_results("random");
  endtask

  task automatic test_ignored_cmds();
    int base;
    model_clear();
    send_cmd(OP_CLEAR, 0);
    base = done_count;
    send_cmd(OP_BLOCK, 6);
    push_sample(fixed_set[0]);
    push_sample(fixed_set[3]);
    in_valid = 1'b0;
    // both dropped while running
    send_cmd(OP_CLEAR, 0);
    send_cmd(OP_BLOCK, 3);
    for (int i = 4; i < 8; i++) push_sample(fixed_set[i]);
    in_valid = 1'b0;
    wait_done("ignore", base);
    // window for a stray second block
    repeat (40) @(posedge clk);
    #1 check_field("ignore", "done_count", 1, done_count - base);
    check_field("ignore", "in_ready", 1'b0, in_ready);
    check_results("ignore");
  endtask

  initial begin
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    test_reset_and_empty();
    test_fixed_block();
    test_accumulate();
    test_random_gaps();
    test_ignored_cmds();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
